// File: src/sldu_pkg.sv
package sldu_pkg;

    // Instruction word width and field positions
    localparam int INSTR_W = 32;
    localparam int F6_MSB  = 31;
    localparam int F6_LSB  = 26;
    localparam int VM_BIT  = 25;
    // Shared vs1 / rs1 / simm5 field
    localparam int VS1_MSB = 19;
    localparam int VS1_LSB = 15;
    localparam int F3_MSB  = 14;
    localparam int F3_LSB  = 12;

    // funct6 values handled by the slide unit
    typedef enum logic [5:0] {
        F6_REDSUM    = 6'b000000,
        F6_REDAND    = 6'b000001,
        F6_REDOR     = 6'b000010,
        F6_REDXOR    = 6'b000011,
        F6_SLIDEUP   = 6'b001110,
        F6_SLIDEDOWN = 6'b001111,
        // vmv.x.s under OPMVV, vmv.s.x under OPMVX
        F6_WXUNARY0  = 6'b010000
    } funct6_e;

    // Operand categories from funct3
    typedef enum logic [2:0] {
        OPIVV = 3'b000,
        OPMVV = 3'b010,
        OPIVI = 3'b011,
        OPIVX = 3'b100,
        OPMVX = 3'b110
    } funct3_e;

    // Decoded operation carried down the pipeline
    typedef enum logic [3:0] {
        OP_NONE,
        OP_SLIDE_UP,
        OP_SLIDE_DN,
        OP_RED_SUM,
        OP_RED_AND,
        OP_RED_OR,
        OP_RED_XOR,
        OP_MV_XS,
        OP_MV_SX
    } sldu_op_e;

    // Beat sequencer states
    typedef enum logic [1:0] {
        SEQ_IDLE,
        SEQ_ISSUE,
        SEQ_DRAIN
    } seq_state_e;

endpackage

// File: src/sldu_decode.sv
module sldu_decode import sldu_pkg::*; #(
    parameter int DATA_WIDTH = 32
) (
    input  logic                  clk_i,
    input  logic                  resetn_i,
    input  logic                  req_i,
    input  logic [INSTR_W-1:0]    instr_i,
    input  logic [DATA_WIDTH-1:0] rs1_rdata_i,
    input  logic [DATA_WIDTH-1:0] lane_mask_rdata_i,
    input  logic                  done_i,
    output logic                  start_o,
    output sldu_op_e              op_o,
    output logic [DATA_WIDTH-1:0] offset_o,
    output logic                  masked_o,
    output logic [DATA_WIDTH-1:0] mask_o,
    output logic [DATA_WIDTH-1:0] rs1_o
);

    localparam int IMM_W = VS1_MSB - VS1_LSB + 1;

    funct6_e               f6;
    funct3_e               f3;
    logic [IMM_W-1:0]      imm;
    sldu_op_e              dec_op;
    logic [DATA_WIDTH-1:0] dec_offset;
    logic                  busy_q;
    logic                  accept;

    // Instruction fields
    assign f6  = funct6_e'(instr_i[F6_MSB:F6_LSB]);
    assign f3  = funct3_e'(instr_i[F3_MSB:F3_LSB]);
    assign imm = instr_i[VS1_MSB:VS1_LSB];

    // Map funct6 and funct3 onto an operation, anything else stays OP_NONE
    always_comb begin
        dec_op = OP_NONE;
        case (f6)
            F6_SLIDEUP:   if (f3 == OPIVX || f3 == OPIVI) dec_op = OP_SLIDE_UP;
            F6_SLIDEDOWN: if (f3 == OPIVX || f3 == OPIVI) dec_op = OP_SLIDE_DN;
            F6_REDSUM:    if (f3 == OPMVV) dec_op = OP_RED_SUM;
            F6_REDAND:    if (f3 == OPMVV) dec_op = OP_RED_AND;
            F6_REDOR:     if (f3 == OPMVV) dec_op = OP_RED_OR;
            F6_REDXOR:    if (f3 == OPMVV) dec_op = OP_RED_XOR;
            F6_WXUNARY0: begin
                // vmv.x.s needs vs1 = 0
                if (f3 == OPMVV && imm == '0) dec_op = OP_MV_XS;
                else if (f3 == OPMVX) dec_op = OP_MV_SX;
            end
            default:      dec_op = OP_NONE;
        endcase
    end

    // Immediate offset is unsigned, zero extended
    assign dec_offset = (f3 == OPIVI) ? {{(DATA_WIDTH-IMM_W){1'b0}}, imm} : rs1_rdata_i;

    // Requests while busy or with unknown encodings are dropped
    assign accept = req_i && !busy_q && (dec_op != OP_NONE);

    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            busy_q   <= 1'b0;
            start_o  <= 1'b0;
            op_o     <= OP_NONE;
            masked_o <= 1'b0;
        end else begin
            start_o <= accept;
            if (accept) begin
                busy_q   <= 1'b1;
                op_o     <= dec_op;
                // vm low means masked
                masked_o <= !instr_i[VM_BIT];
            end else if (done_i) begin
                busy_q <= 1'b0;
            end
        end
    end

    // Operands held for the whole instruction
    always_ff @(posedge clk_i) begin
        if (accept) begin
            offset_o <= dec_offset;
            mask_o   <= lane_mask_rdata_i;
            rs1_o    <= rs1_rdata_i;
        end
    end

endmodule

// File: src/sldu_sequencer.sv
module sldu_sequencer import sldu_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int LANES      = 4,
    parameter int VLEN       = 512
) (
    input  logic             clk_i,
    input  logic             resetn_i,
    input  logic             start_i,
    input  sldu_op_e         op_i,
    output logic [SEL_W-1:0] vs2_elem_sel_o,
    output logic             beat_valid_o,
    output logic             beat_last_o,
    output logic [SEL_W-1:0] beat_idx_o,
    output sldu_op_e         beat_op_o
);

    localparam int ELEM_N = VLEN / DATA_WIDTH;
    localparam int BEATS  = ELEM_N / LANES;
    localparam int SEL_W  = $clog2(BEATS);

    seq_state_e       state_q;
    seq_state_e       state_d;
    logic [SEL_W-1:0] cnt_q;
    logic [SEL_W-1:0] cnt_d;
    logic             issue_valid;
    logic             issue_last;
    logic [SEL_W-1:0] issue_idx;
    logic             is_move;

    // Scalar moves only touch element 0
    assign is_move = (op_i == OP_MV_XS) || (op_i == OP_MV_SX);

    always_comb begin
        state_d     = state_q;
        cnt_d       = cnt_q;
        issue_valid = 1'b0;
        issue_idx   = cnt_q;
        case (state_q)
            // Beat 0 goes out in the same cycle as the start pulse
            SEQ_IDLE: begin
                if (start_i) begin
                    issue_valid = 1'b1;
                    issue_idx   = '0;
                end
            end
            SEQ_ISSUE: issue_valid = 1'b1;
            // Last beat is in the data stage here
            SEQ_DRAIN: state_d = SEQ_IDLE;
            default:   state_d = SEQ_IDLE;
        endcase
        issue_last = is_move || (issue_idx == SEL_W'(BEATS - 1));
        if (issue_valid) begin
            cnt_d   = issue_idx + 1'b1;
            state_d = issue_last ? SEQ_DRAIN : SEQ_ISSUE;
        end
    end

    // Shared select for all lanes
    assign vs2_elem_sel_o = issue_idx;

    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            state_q      <= SEQ_IDLE;
            cnt_q        <= '0;
            beat_valid_o <= 1'b0;
            beat_last_o  <= 1'b0;
        end else begin
            state_q      <= state_d;
            cnt_q        <= cnt_d;
            beat_valid_o <= issue_valid;
            beat_last_o  <= issue_valid && issue_last;
        end
    end

    // Beat tag follows the one cycle lane read latency
    always_ff @(posedge clk_i) begin
        beat_idx_o <= issue_idx;
        beat_op_o  <= op_i;
    end

endmodule

// File: src/sldu_lane_xbar.sv
module sldu_lane_xbar import sldu_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int LANES      = 4,
    parameter int VLEN       = 512
) (
    input  logic                  clk_i,
    input  logic                  resetn_i,
    input  logic                  beat_valid_i,
    input  logic                  beat_last_i,
    input  logic [SEL_W-1:0]      beat_idx_i,
    input  sldu_op_e              beat_op_i,
    input  logic [DATA_WIDTH-1:0] offset_i,
    input  logic                  masked_i,
    input  logic [DATA_WIDTH-1:0] mask_i,
    input  logic [DATA_WIDTH-1:0] rs1_i,
    input  logic [DATA_WIDTH-1:0] lane_vs2_rdata_i   [LANES],
    input  logic [DATA_WIDTH-1:0] red_result_i,
    input  logic                  red_done_i,
    output logic [DATA_WIDTH-1:0] lane_vd_wdata_o    [LANES],
    output logic                  lane_vd_wr_en_o    [LANES],
    output logic [SEL_W-1:0]      lane_vd_elem_sel_o [LANES],
    output logic                  ready_o
);

    localparam int ELEM_N = VLEN / DATA_WIDTH;
    localparam int BEATS  = ELEM_N / LANES;
    localparam int SEL_W  = $clog2(BEATS);
    localparam int IDX_W  = $clog2(ELEM_N);
    localparam int LANE_W = $clog2(LANES);

    logic                  slide_up;
    logic                  slide_op;
    logic                  mv_sx;
    logic [LANE_W-1:0]     rot;
    logic [DATA_WIDTH-1:0] wdata_d [LANES];
    logic                  wr_en_d [LANES];
    logic [SEL_W-1:0]      sel_d   [LANES];

    assign slide_up = (beat_op_i == OP_SLIDE_UP);
    assign slide_op = slide_up || (beat_op_i == OP_SLIDE_DN);
    assign mv_sx    = beat_valid_i && (beat_op_i == OP_MV_SX);
    // A fixed offset moves the whole beat by the same lane distance
    assign rot      = offset_i[LANE_W-1:0];

    always_comb begin
        logic [LANE_W-1:0]   src_lane;
        logic [DATA_WIDTH:0] s_ext;
        logic [DATA_WIDTH:0] d_ext;
        for (int k = 0; k < LANES; k++) begin
            // Source lane feeding destination lane k
            src_lane = slide_up ? LANE_W'(k) - rot : LANE_W'(k) + rot;
            s_ext    = {{(DATA_WIDTH + 1 - IDX_W){1'b0}}, beat_idx_i, src_lane};
            // Extra bit keeps the carry, and a borrow reads as out of range
            d_ext    = slide_up ? s_ext + {1'b0, offset_i} : s_ext - {1'b0, offset_i};
            wdata_d[k] = lane_vs2_rdata_i[src_lane];
            sel_d[k]   = d_ext[IDX_W-1:LANE_W];
            wr_en_d[k] = beat_valid_i && slide_op
                         && (d_ext < (DATA_WIDTH + 1)'(ELEM_N))
                         && (!masked_i || mask_i[d_ext[IDX_W-1:0]]);
        end
        // Scalar results land in element 0 of lane 0
        if (mv_sx || red_done_i) begin
            wdata_d[0] = mv_sx ? rs1_i : red_result_i;
            sel_d[0]   = '0;
            wr_en_d[0] = 1'b1;
        end
    end

    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            ready_o <= 1'b0;
            for (int k = 0; k < LANES; k++) begin
                lane_vd_wr_en_o[k] <= 1'b0;
            end
        end else begin
            // Done together with the last write of the instruction
            ready_o <= beat_valid_i && beat_last_i;
            for (int k = 0; k < LANES; k++) begin
                lane_vd_wr_en_o[k] <= wr_en_d[k];
            end
        end
    end

    always_ff @(posedge clk_i) begin
        for (int k = 0; k < LANES; k++) begin
            lane_vd_wdata_o[k]    <= wdata_d[k];
            lane_vd_elem_sel_o[k] <= sel_d[k];
        end
    end

endmodule

// File: src/sldu_reduce_move.sv
module sldu_reduce_move import sldu_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int LANES      = 4,
    parameter int VLEN       = 512
) (
    input  logic                  clk_i,
    input  logic                  resetn_i,
    input  logic                  beat_valid_i,
    input  logic                  beat_last_i,
    input  logic [SEL_W-1:0]      beat_idx_i,
    input  sldu_op_e              beat_op_i,
    input  logic                  masked_i,
    input  logic [DATA_WIDTH-1:0] mask_i,
    input  logic [DATA_WIDTH-1:0] lane_vs2_rdata_i [LANES],
    output logic [DATA_WIDTH-1:0] red_result_o,
    output logic                  red_done_o,
    output logic [DATA_WIDTH-1:0] rd_wdata_o,
    output logic                  rd_wr_en_o
);

    localparam int ELEM_N = VLEN / DATA_WIDTH;
    localparam int BEATS  = ELEM_N / LANES;
    localparam int SEL_W  = $clog2(BEATS);
    localparam int LANE_W = $clog2(LANES);

    logic                  is_red;
    logic                  mv_xs;
    logic [DATA_WIDTH-1:0] ident;
    logic [DATA_WIDTH-1:0] acc_q;
    logic [DATA_WIDTH-1:0] red_d;

    // Two operand step of the selected reduction
    function automatic logic [DATA_WIDTH-1:0] red_step(sldu_op_e op,
                                                       logic [DATA_WIDTH-1:0] a,
                                                       logic [DATA_WIDTH-1:0] b);
        logic [DATA_WIDTH-1:0] r;
        case (op)
            OP_RED_AND: r = a & b;
            OP_RED_OR:  r = a | b;
            OP_RED_XOR: r = a ^ b;
            default:    r = a + b;
        endcase
        return r;
    endfunction

    assign is_red = (beat_op_i == OP_RED_SUM) || (beat_op_i == OP_RED_AND)
                    || (beat_op_i == OP_RED_OR) || (beat_op_i == OP_RED_XOR);
    assign mv_xs  = beat_valid_i && (beat_op_i == OP_MV_XS);
    // All ones for and, zero for the others
    assign ident  = (beat_op_i == OP_RED_AND) ? '1 : '0;

    always_comb begin
        logic [DATA_WIDTH-1:0] elem;
        // Beat 0 restarts from the identity
        red_d = (beat_idx_i == '0) ? ident : acc_q;
        for (int l = 0; l < LANES; l++) begin
            // Masked off elements contribute the identity
            elem  = (!masked_i || mask_i[{beat_idx_i, LANE_W'(l)}]) ? lane_vs2_rdata_i[l] : ident;
            red_d = red_step(beat_op_i, red_d, elem);
        end
    end

    assign red_result_o = red_d;
    assign red_done_o   = beat_valid_i && beat_last_i && is_red;

    always_ff @(posedge clk_i) begin
        if (beat_valid_i && is_red) begin
            acc_q <= red_d;
        end
        if (mv_xs) begin
            // vs2 element 0 sits in lane 0 at select 0
            rd_wdata_o <= lane_vs2_rdata_i[0];
        end
    end

    always_ff @(posedge clk_i or negedge resetn_i) begin
        if (!resetn_i) begin
            rd_wr_en_o <= 1'b0;
        end else begin
            rd_wr_en_o <= mv_xs;
        end
    end

endmodule

// File: src/sldu_top.sv
module sldu_top import sldu_pkg::*; #(
    parameter int DATA_WIDTH = 32,
    parameter int LANES      = 4,
    parameter int VLEN       = 512
) (
    input  logic                  clk_i,
    input  logic                  resetn_i,
    input  logic                  req_i,
    input  logic [INSTR_W-1:0]    instr_i,
    input  logic [DATA_WIDTH-1:0] rs1_rdata_i,
    input  logic [DATA_WIDTH-1:0] lane_mask_rdata_i,
    input  logic [DATA_WIDTH-1:0] lane_vs2_rdata_i   [LANES],
    output logic [SEL_W-1:0]      lane_vs2_elem_sel_o,
    output logic [DATA_WIDTH-1:0] lane_vd_wdata_o    [LANES],
    output logic                  lane_vd_wr_en_o    [LANES],
    output logic [SEL_W-1:0]      lane_vd_elem_sel_o [LANES],
    output logic [DATA_WIDTH-1:0] rd_wdata_o,
    output logic                  rd_wr_en_o,
    output logic                  ready_o
);

    localparam int ELEM_N = VLEN / DATA_WIDTH;
    localparam int BEATS  = ELEM_N / LANES;
    localparam int SEL_W  = $clog2(BEATS);

    // Decode to sequencer and data stages
    logic                  start;
    sldu_op_e              op;
    logic [DATA_WIDTH-1:0] offset;
    logic                  masked;
    logic [DATA_WIDTH-1:0] mask;
    logic [DATA_WIDTH-1:0] rs1;
    // Beat tag aligned with lane read data
    logic                  beat_valid;
    logic                  beat_last;
    logic [SEL_W-1:0]      beat_idx;
    sldu_op_e              beat_op;
    // Reduction result toward the crossbar
    logic [DATA_WIDTH-1:0] red_result;
    logic                  red_done;

    sldu_decode #(.DATA_WIDTH(DATA_WIDTH)) i_decode (
        .clk_i, .resetn_i, .req_i, .instr_i, .rs1_rdata_i, .lane_mask_rdata_i,
        .done_i   (ready_o),
        .start_o  (start),
        .op_o     (op),
        .offset_o (offset),
        .masked_o (masked),
        .mask_o   (mask),
        .rs1_o    (rs1)
    );

    sldu_sequencer #(.DATA_WIDTH(DATA_WIDTH), .LANES(LANES), .VLEN(VLEN)) i_sequencer (
        .clk_i, .resetn_i,
        .start_i        (start),
        .op_i           (op),
        .vs2_elem_sel_o (lane_vs2_elem_sel_o),
        .beat_valid_o   (beat_valid),
        .beat_last_o    (beat_last),
        .beat_idx_o     (beat_idx),
        .beat_op_o      (beat_op)
    );

    sldu_lane_xbar #(.DATA_WIDTH(DATA_WIDTH), .LANES(LANES), .VLEN(VLEN)) i_lane_xbar (
        .clk_i, .resetn_i, .lane_vs2_rdata_i,
        .beat_valid_i (beat_valid), .beat_last_i (beat_last),
        .beat_idx_i   (beat_idx),   .beat_op_i   (beat_op),
        .offset_i     (offset),     .masked_i    (masked),
        .mask_i       (mask),       .rs1_i       (rs1),
        .red_result_i (red_result), .red_done_i  (red_done),
        .lane_vd_wdata_o, .lane_vd_wr_en_o, .lane_vd_elem_sel_o, .ready_o
    );

    sldu_reduce_move #(.DATA_WIDTH(DATA_WIDTH), .LANES(LANES), .VLEN(VLEN)) i_reduce_move (
        .clk_i, .resetn_i, .lane_vs2_rdata_i,
        .beat_valid_i (beat_valid), .beat_last_i (beat_last),
        .beat_idx_i   (beat_idx),   .beat_op_i   (beat_op),
        .masked_i     (masked),     .mask_i      (mask),
        .red_result_o (red_result), .red_done_o  (red_done),
        .rd_wdata_o, .rd_wr_en_o
    );

endmodule

// File: bench/sldu_lane_model.sv
module sldu_lane_model #(
    parameter int DATA_WIDTH = 32,
    parameter int LANES      = 4,
    parameter int VLEN       = 512
) (
    input  logic                  clk_i,
    input  logic [SEL_W-1:0]      vs2_elem_sel_i,
    output logic [DATA_WIDTH-1:0] vs2_rdata_o   [LANES],
    input  logic [DATA_WIDTH-1:0] vd_wdata_i    [LANES],
    input  logic                  vd_wr_en_i    [LANES],
    input  logic [SEL_W-1:0]      vd_elem_sel_i [LANES]
);

    timeunit 1ns;
    timeprecision 1ps;

    localparam int ELEM_N = VLEN / DATA_WIDTH;
    localparam int BEATS  = ELEM_N / LANES;
    localparam int SEL_W  = $clog2(BEATS);

    // Both registers stored by element index, lane = e mod LANES
    logic [DATA_WIDTH-1:0] vs2_mem [ELEM_N];
    logic [DATA_WIDTH-1:0] vd_mem  [ELEM_N];
    int                    seed;

    // Random vs2 contents and random old vd values
    initial begin
        seed = 51;
        for (int e = 0; e < ELEM_N; e++) begin
            vs2_mem[e] = $random(seed);
            vd_mem[e]  = $random(seed);
        end
    end

    always @(posedge clk_i) begin
        for (int l = 0; l < LANES; l++) begin
            // Read data one cycle after the select
            vs2_rdata_o[l] <= vs2_mem[int'(vs2_elem_sel_i) * LANES + l];
            if (vd_wr_en_i[l] === 1'b1) begin
                vd_mem[int'(vd_elem_sel_i[l]) * LANES + l] <= vd_wdata_i[l];
            end
        end
    end

endmodule

// File: bench/sldu_tb.sv
module sldu_tb import sldu_pkg::*; ();

    timeunit 1ns;
    timeprecision 1ps;

    localparam int DATA_WIDTH = 32;
    localparam int LANES      = 4;
    localparam int VLEN       = 512;
    localparam int ELEM_N     = VLEN / DATA_WIDTH;
    localparam int BEATS      = ELEM_N / LANES;
    localparam int SEL_W      = $clog2(BEATS);
    localparam int TIMEOUT    = 40;

    logic                  clk_i;
    logic                  resetn_i;
    logic                  req_i;
    logic [INSTR_W-1:0]    instr_i;
    logic [DATA_WIDTH-1:0] rs1_rdata_i;
    logic [DATA_WIDTH-1:0] lane_mask_rdata_i;
    logic [DATA_WIDTH-1:0] lane_vs2_rdata_i   [LANES];
    logic [SEL_W-1:0]      lane_vs2_elem_sel_o;
    logic [DATA_WIDTH-1:0] lane_vd_wdata_o    [LANES];
    logic                  lane_vd_wr_en_o    [LANES];
    logic [SEL_W-1:0]      lane_vd_elem_sel_o [LANES];
    logic [DATA_WIDTH-1:0] rd_wdata_o;
    logic                  rd_wr_en_o;
    logic                  ready_o;
    // High while an accepted instruction may write
    logic                  active;
    // Expected vd contents after the running instruction
    logic [DATA_WIDTH-1:0] exp_vd [ELEM_N];

    sldu_top #(.DATA_WIDTH(DATA_WIDTH), .LANES(LANES), .VLEN(VLEN)) i_dut (
        .clk_i, .resetn_i, .req_i, .instr_i, .rs1_rdata_i, .lane_mask_rdata_i,
        .lane_vs2_rdata_i, .lane_vs2_elem_sel_o, .lane_vd_wdata_o, .lane_vd_wr_en_o,
        .lane_vd_elem_sel_o, .rd_wdata_o, .rd_wr_en_o, .ready_o
    );

    sldu_lane_model #(.DATA_WIDTH(DATA_WIDTH), .LANES(LANES), .VLEN(VLEN)) i_lanes (
        .clk_i,
        .vs2_elem_sel_i (lane_vs2_elem_sel_o),
        .vs2_rdata_o    (lane_vs2_rdata_i),
        .vd_wdata_i     (lane_vd_wdata_o),
        .vd_wr_en_i     (lane_vd_wr_en_o),
        .vd_elem_sel_i  (lane_vd_elem_sel_o)
    );

    initial begin
        clk_i = 1'b0;
        forever #20 clk_i = ~clk_i;
    end

    task automatic fail_test(input string msg);
        $display("%s", msg);
        $display("Test FAILED");
        $fatal(1, "simulation stopped on first error");
    endtask

    // vs2 = 8 and vd = 4 are arbitrary, the unit only sees the word
    function automatic logic [INSTR_W-1:0] encode_instr(funct6_e f6, logic vm,
                                                        logic [4:0] field, funct3_e f3);
        return {f6, vm, 5'd8, field, f3, 5'd4, 7'b1010111};
    endfunction

    function automatic logic [DATA_WIDTH-1:0] red_fold(funct6_e f6, logic [DATA_WIDTH-1:0] a,
                                                       logic [DATA_WIDTH-1:0] b);
        case (f6)
            F6_REDAND: return a & b;
            F6_REDOR:  return a | b;
            F6_REDXOR: return a ^ b;
            default:   return a + b;
        endcase
    endfunction

    // No write, no rd write and no ready between instructions
    always @(posedge clk_i) begin
        if (resetn_i && !active) begin
            assert (ready_o === 1'b0 && rd_wr_en_o === 1'b0)
                else fail_test($sformatf("MISMATCH at %0t: ready_o or rd_wr_en_o while idle",
                                         $time));
            for (int l = 0; l < LANES; l++) begin
                assert (lane_vd_wr_en_o[l] === 1'b0)
                    else fail_test($sformatf("MISMATCH at %0t: lane %0d write while idle",
                                             $time, l));
            end
        end
    end

    task automatic snapshot_vd();
        for (int e = 0; e < ELEM_N; e++) begin
            exp_vd[e] = i_lanes.vd_mem[e];
        end
    endtask

    task automatic check_vd();
        for (int e = 0; e < ELEM_N; e++) begin
            assert (i_lanes.vd_mem[e] === exp_vd[e])
                else fail_test($sformatf("MISMATCH at %0t: vd[%0d] is %h, expected %h",
                                         $time, e, i_lanes.vd_mem[e], exp_vd[e]));
        end
    endtask

    // Destination d takes source d - off (up) or d + off (down)
    task automatic expect_slide(input bit up, input int off, input bit masked,
                                input logic [DATA_WIDTH-1:0] mask);
        int s;
        for (int d = 0; d < ELEM_N; d++) begin
            s = up ? d - off : d + off;
            if (s >= 0 && s < ELEM_N && (!masked || mask[d])) begin
                exp_vd[d] = i_lanes.vs2_mem[s];
            end
        end
    endtask

    task automatic run_instr(input logic [INSTR_W-1:0] instr, input logic [DATA_WIDTH-1:0] rs1,
                             input logic [DATA_WIDTH-1:0] mask, input int exp_ready,
                             input int exp_rd, input bit inject_busy);
        int                    cycles;
        int                    rd_cycle;
        logic [DATA_WIDTH-1:0] rd_val;
        @(posedge clk_i);
        req_i             <= 1'b1;
        instr_i           <= instr;
        rs1_rdata_i       <= rs1;
        lane_mask_rdata_i <= mask;
        active            <= 1'b1;
        // Request sampled here, cycle count starts at 0
        @(posedge clk_i);
        req_i    <= 1'b0;
        cycles   = 0;
        rd_cycle = 0;
        rd_val   = '0;
        do begin
            @(posedge clk_i);
            cycles++;
            // vmv.s.x while busy, which must leave vd[0] alone
            if (inject_busy && cycles == 2) begin
                req_i       <= 1'b1;
                instr_i     <= encode_instr(F6_WXUNARY0, 1'b1, 5'd0, OPMVX);
                rs1_rdata_i <= 32'hcafe_f00d;
            end else begin
                req_i <= 1'b0;
            end
            if (rd_wr_en_o === 1'b1) begin
                assert (rd_cycle == 0)
                    else fail_test($sformatf("MISMATCH at %0t: second rd write", $time));
                rd_cycle = cycles;
                rd_val   = rd_wdata_o;
            end
            if (cycles > TIMEOUT) begin
                fail_test("Timeout while waiting for ready_o");
            end
        end while (ready_o !== 1'b1);
        // Idle checks cover every cycle after the ready_o pulse
        active <= 1'b0;
        assert (cycles == exp_ready)
            else fail_test($sformatf("MISMATCH at %0t: ready_o after %0d cycles, expected %0d",
                                     $time, cycles, exp_ready));
        assert (rd_cycle == exp_rd)
            else fail_test($sformatf("MISMATCH at %0t: rd write in cycle %0d, expected %0d",
                                     $time, rd_cycle, exp_rd));
        if (exp_rd != 0) begin
            assert (rd_val === i_lanes.vs2_mem[0])
                else fail_test($sformatf("MISMATCH at %0t: rd is %h, expected %h",
                                         $time, rd_val, i_lanes.vs2_mem[0]));
        end
        @(posedge clk_i);
        assert (ready_o === 1'b0)
            else fail_test($sformatf("MISMATCH at %0t: ready_o longer than one cycle", $time));
        check_vd();
    endtask

    // Dropped encodings give no ready and no write
    task automatic drop_instr(input logic [INSTR_W-1:0] instr);
        snapshot_vd();
        @(posedge clk_i);
        req_i   <= 1'b1;
        instr_i <= instr;
        @(posedge clk_i);
        req_i <= 1'b0;
        // Longer than the slowest instruction
        for (int c = 0; c < BEATS + 4; c++) begin
            @(posedge clk_i);
        end
        check_vd();
    endtask

    task automatic slide_case(input bit up, input bit use_imm, input int off, input bit masked,
                              input logic [DATA_WIDTH-1:0] mask, input bit inject_busy);
        funct6_e f6;
        funct3_e f3;
        if (up) f6 = F6_SLIDEUP;
        else    f6 = F6_SLIDEDOWN;
        if (use_imm) f3 = OPIVI;
        else         f3 = OPIVX;
        snapshot_vd();
        expect_slide(up, off, masked, mask);
        // rs1 is all ones for the immediate form, so a wrong source shows up
        run_instr(encode_instr(f6, !masked, use_imm ? 5'(off) : 5'd0, f3),
                  use_imm ? '1 : DATA_WIDTH'(off), mask, 2 + BEATS, 0, inject_busy);
    endtask

    task automatic reduce_case(input funct6_e f6, input bit masked,
                               input logic [DATA_WIDTH-1:0] mask);
        logic [DATA_WIDTH-1:0] acc;
        snapshot_vd();
        // Identity of the operator
        acc = (f6 == F6_REDAND) ? '1 : '0;
        for (int e = 0; e < ELEM_N; e++) begin
            if (!masked || mask[e]) acc = red_fold(f6, acc, i_lanes.vs2_mem[e]);
        end
        exp_vd[0] = acc;
        run_instr(encode_instr(f6, !masked, 5'd0, OPMVV), '0, mask, 2 + BEATS, 0, 1'b0);
    endtask

    initial begin
        resetn_i          = 1'b0;
        req_i             = 1'b0;
        instr_i           = '0;
        rs1_rdata_i       = '0;
        lane_mask_rdata_i = '0;
        active            = 1'b0;
        repeat (5) @(posedge clk_i);
        resetn_i <= 1'b1;
        // Vector offset slide and vmv.x.s with nonzero vs1
        drop_instr(encode_instr(F6_SLIDEUP, 1'b1, 5'd2, OPIVV));
        drop_instr(encode_instr(F6_WXUNARY0, 1'b1, 5'd1, OPMVV));
        slide_case(1'b1, 1'b0, 3, 1'b0, '0, 1'b1);
        slide_case(1'b0, 1'b1, 5, 1'b0, '0, 1'b0);
        slide_case(1'b1, 1'b1, 6, 1'b1, 32'h0000_a5c3, 1'b0);
        slide_case(1'b0, 1'b0, 2, 1'b1, 32'h0000_3c96, 1'b0);
        // Offset past the vector end writes nothing
        slide_case(1'b1, 1'b0, 20, 1'b0, '0, 1'b0);
        for (int m = 0; m < 2; m++) begin
            reduce_case(F6_REDSUM, m[0], 32'h0000_6b1d);
            reduce_case(F6_REDAND, m[0], 32'h0000_0412);
            reduce_case(F6_REDOR,  m[0], 32'h0000_8421);
            reduce_case(F6_REDXOR, m[0], 32'h0000_f0e1);
        end
        // vmv.x.s then vmv.s.x
        snapshot_vd();
        run_instr(encode_instr(F6_WXUNARY0, 1'b1, 5'd0, OPMVV), '0, '0, 3, 3, 1'b0);
        snapshot_vd();
        exp_vd[0] = 32'h1234_5678;
        run_instr(encode_instr(F6_WXUNARY0, 1'b1, 5'd0, OPMVX), 32'h1234_5678, '0, 3, 0, 1'b0);
        $display("Test OK");
        $finish;
    end

endmodule

// File: list.f
src/sldu_pkg.sv
src/sldu_decode.sv
src/sldu_sequencer.sv
src/sldu_lane_xbar.sv
src/sldu_reduce_move.sv
src/sldu_top.sv
bench/sldu_lane_model.sv
bench/sldu_tb.sv

// File: Bender.yml
package:
  name: sldu

sources:
  - src/sldu_pkg.sv
  - src/sldu_decode.sv
  - src/sldu_sequencer.sv
  - src/sldu_lane_xbar.sv
  - src/sldu_reduce_move.sv
  - src/sldu_top.sv
  - target: test
    files:
      - bench/sldu_lane_model.sv
      - bench/sldu_tb.sv
